// ==== vlog.f ====
hw/aead_ctrl_pkg.sv
hw/cmd_decoder.sv
hw/block_formatter.sv
hw/tag_checker.sv
hw/aead_sequencer.sv
hw/aead_ctrl.sv
tb/cipher_stub.sv
tb/tb_aead_ctrl.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f vlog.f --top-module tb_aead_ctrl -o tb_aead_ctrl
./obj_dir/tb_aead_ctrl > sim.log
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
	exit 0
else
	exit 1
fi

// ==== tb/tb_aead_ctrl.sv ====
`default_nettype none

module tb_aead_ctrl;

	import aead_ctrl_pkg::*;

	localparam int block_words = 4;
	localparam int wait_limit = 40;

	typedef enum logic [3:0] {
		lbl_reset,
		lbl_idle,
		lbl_key,
		lbl_nonce,
		lbl_lmask,
		lbl_word,
		lbl_wait,
		lbl_tag_out,
		lbl_tag_verify
	} label_e;

	// what the current cycle is expected to be
	typedef struct packed {
		label_e label;
		logic final_word;
		logic msg;
		logic dec;
		logic verify_last;
		logic exp_fail;
		logic [len_width-1:0] len;
	} cycle_ctx_t;

	logic clk;
	logic rst;
	logic [data_width-1:0] pdi_data;
	logic pdi_valid;
	logic last;
	logic [data_width-1:0] pdo;
	logic [rc_width-1:0] rc;
	logic [data_width-1:0] pdi;
	logic pdi_ready;
	logic pdo_valid;
	state_ctl_t st_ctl;
	key_ctl_t key_ctl;
	logic erst;
	logic sl;
	logic [3:0] decrypt;
	logic correct_cnt;
	logic fail;
	logic [dom_width-1:0] dom_old;
	logic [dom_width-1:0] dom_new;

	logic [3:0] stub_delay;
	cycle_ctx_t ctx;
	logic [31:0] seed;
	int value_errors = 0;
	int wait_errors = 0;
	int fail_errors = 0;
	int timeouts = 0;

	aead_ctrl #(
		.block_words (block_words)
	) u_dut (
		.clk         (clk),
		.rst         (rst),
		.pdi_data    (pdi_data),
		.pdi_valid   (pdi_valid),
		.last        (last),
		.pdo         (pdo),
		.rc          (rc),
		.pdi         (pdi),
		.pdi_ready   (pdi_ready),
		.pdo_valid   (pdo_valid),
		.st_ctl      (st_ctl),
		.key_ctl     (key_ctl),
		.erst        (erst),
		.sl          (sl),
		.decrypt     (decrypt),
		.correct_cnt (correct_cnt),
		.fail        (fail),
		.dom_old     (dom_old),
		.dom_new     (dom_new)
	);

	cipher_stub u_stub (
		.clk      (clk),
		.rst      (rst),
		.st_ctl   (st_ctl),
		.key_ctl  (key_ctl),
		.wait_len (stub_delay),
		.rc       (rc)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic pick(input int span, output int r);
		seed = xorshift32(seed);
		r = int'(seed % 32'(span));
	endtask

	task automatic rand_word(output logic [31:0] w);
		seed = xorshift32(seed);
		w = seed;
	endtask

	function automatic cycle_ctx_t plain(input label_e lbl);
		cycle_ctx_t c;
		c = '0;
		c.label = lbl;
		return c;
	endfunction

	// domain byte of a final word
	function automatic logic [dom_width-1:0] rule_dom(input logic v, input logic l,
			input logic [len_width-1:0] len, input logic msg);
		if (v && l && len == '0) begin
			return msg ? dom_msg_final : dom_ad_final;
		end else if (v && !l) begin
			return msg ? dom_msg_normal : dom_ad_normal;
		end else begin
			return msg ? dom_msg_padded : dom_ad_padded;
		end
	endfunction

	function automatic logic [data_width-1:0] rule_pdi(input logic v, input logic l,
			input logic [len_width-1:0] len, input logic [data_width-1:0] d);
		if (!v) begin
			return data_width'(len);
		end else if (l && len != '0) begin
			return {d[data_width-1:len_width], len};   // length in low nibble
		end else begin
			return d;
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got == exp) else begin
			value_errors++;
			$display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	always @(posedge clk) begin
		if (!rst) begin
			check_value("correct_cnt", 32'(correct_cnt), 32'(ctx.label != lbl_wait));
			case (ctx.label)
				lbl_reset, lbl_idle: begin
					check_value("pdi_ready", 32'(pdi_ready), 1);
					check_value("pdo_valid", 32'(pdo_valid), 0);
					check_value("fail", 32'(fail), 0);
					check_value("key_ctl", 32'(key_ctl), 0);
					check_value("erst", 32'(erst), 0);
					check_value("sl", 32'(sl), 0);
					if (ctx.label == lbl_reset) begin
						check_value("dom_old", 32'(dom_old), 0);
					end
				end
				lbl_key: check_value("key_ctl", 32'(key_ctl), 7);
				lbl_nonce: begin
					check_value("pdi_ready", 32'(pdi_ready), 1);
					check_value("st_ctl.enc", 32'(st_ctl.enc), 1);
					check_value("st_ctl.se", 32'(st_ctl.se), 1);
				end
				lbl_lmask: begin
					check_value("sl", 32'(sl), 1);
					check_value("pdi", pdi, 0);
				end
				lbl_word: begin
					if (ctx.final_word) begin
						check_value("dom_new", 32'(dom_new),
							32'(rule_dom(pdi_valid, last, ctx.len, ctx.msg)));
						check_value("pdi", pdi, rule_pdi(pdi_valid, last, ctx.len, pdi_data));
						if (!pdi_valid) begin
							check_value("pdi_ready", 32'(pdi_ready), 0);
						end
					end else begin
						check_value("pdi", pdi, pdi_valid ? pdi_data : '0);
						check_value("pdi_ready", 32'(pdi_ready), 32'(pdi_valid));
					end
					check_value("pdo_valid", 32'(pdo_valid), 32'(ctx.msg && pdi_valid));
					check_value("decrypt", 32'(decrypt), (ctx.msg && ctx.dec) ? 15 : 0);
				end
				lbl_tag_out: check_value("pdo_valid", 32'(pdo_valid), 1);
				lbl_tag_verify: begin
					check_value("pdo_valid", 32'(pdo_valid), 32'(ctx.verify_last));
					check_value("fail", 32'(fail), 32'(ctx.verify_last && ctx.exp_fail));
				end
				default: ;
			endcase
		end
	end

	// no word is taken while the cipher runs
	assert property (@(posedge clk) disable iff (rst)
		(!correct_cnt && rc != rc_final) |-> !pdi_ready)
		else begin
			wait_errors++;
			$display("pdi_ready went high during a cipher wait at %0t", $time);
		end

	assert property (@(posedge clk) disable iff (rst) fail |-> pdo_valid)
		else begin
			fail_errors++;
			$display("fail was raised without pdo_valid at %0t", $time);
		end

	task automatic drive(input logic v, input logic [data_width-1:0] d, input logic l,
			input cycle_ctx_t c);
		@(posedge clk);
		pdi_valid <= v;
		pdi_data <= d;
		last <= l;
		ctx <= c;
	endtask

	task automatic cipher_wait(input logic next_valid);
		int span;
		int n;
		logic seen;
		pick(8, span);
		n = 0;
		seen = 1'b0;
		while (!seen && n < wait_limit) begin
			drive(next_valid, '0, 1'b0, plain(lbl_wait));
			if (n == 0) begin
				stub_delay <= 4'(span + 1);   // new delay per wait
			end
			@(negedge clk);
			seen = (rc == rc_final);
			n++;
		end
		if (!seen) begin
			timeouts++;
			$display("timeout: no final round constant after %0d wait cycles", n);
		end
	endtask

	task automatic send_block(input logic msg, input logic dec,
			input logic [len_width-1:0] len, input int present, input logic end_of_data);
		cycle_ctx_t c;
		logic [data_width-1:0] w;
		int i;
		for (i = 0; i < block_words; i++) begin
			rand_word(w);
			c = plain(lbl_word);
			c.final_word = (i == block_words - 1);
			c.msg = msg;
			c.dec = dec;
			c.len = len;
			drive(i < present, w, end_of_data && (i == present - 1), c);
		end
	endtask

	// bad_pos below zero keeps the tag clean
	task automatic run_op(input logic dec, input int ad_blocks, input int msg_blocks,
			input int ad_present, input int msg_present, input int bad_pos);
		logic [len_width-1:0] ad_len;
		logic [len_width-1:0] msg_len;
		logic [data_width-1:0] w;
		cycle_ctx_t c;
		int b;
		int i;
		int r;
		pick(16, r);
		ad_len = len_width'(r);
		pick(16, r);
		msg_len = len_width'(r);
		drive(1'b1, {dec ? op_dec : op_enc, 20'h00000, ad_len, msg_len}, 1'b0,
			plain(lbl_idle));
		for (i = 0; i < block_words; i++) begin
			rand_word(w);
			drive(1'b1, w, 1'b0, plain(lbl_nonce));
		end
		cipher_wait(1'b0);
		if (timeouts != 0) return;
		for (i = 0; i < block_words; i++) begin
			rand_word(w);
			drive(1'b1, w, 1'b0, plain(lbl_lmask));
		end
		for (b = 0; b < ad_blocks; b++) begin
			send_block(1'b0, dec, ad_len, (b == ad_blocks - 1) ? ad_present : block_words,
				b == ad_blocks - 1);
			cipher_wait(b < ad_blocks - 1);
			if (timeouts != 0) return;
		end
		for (b = 0; b < msg_blocks; b++) begin
			send_block(1'b1, dec, msg_len, (b == msg_blocks - 1) ? msg_present : block_words,
				b == msg_blocks - 1);
			cipher_wait(b < msg_blocks - 1);
			if (timeouts != 0) return;
		end
		for (i = 0; i < block_words; i++) begin
			c = plain(dec ? lbl_tag_verify : lbl_tag_out);
			c.verify_last = dec && (i == block_words - 1);
			c.exp_fail = (bad_pos >= 0);
			drive(1'b0, '0, 1'b0, c);
			rand_word(w);
			pdo <= (dec && i == bad_pos) ? (w | 32'h1) : '0;
		end
		drive(1'b0, '0, 1'b0, plain(lbl_idle));
		pdo <= '0;
	endtask

	initial begin
		logic [31:0] w;
		int k;
		int ad_n;
		int msg_n;
		int ad_p;
		int msg_p;
		int pos;
		rst = 1'b1;
		pdi_valid = 1'b0;
		pdi_data = '0;
		last = 1'b0;
		pdo = '0;
		stub_delay = 4'd1;
		ctx = plain(lbl_reset);
		seed = 32'd64532;
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		drive(1'b1, {op_ldkey, 28'h0}, 1'b0, plain(lbl_idle));
		for (k = 0; k < block_words; k++) begin
			rand_word(w);
			drive(1'b1, w, 1'b0, plain(lbl_key));
		end
		drive(1'b0, '0, 1'b0, plain(lbl_idle));

		for (k = 0; k < 3 && timeouts == 0; k++) begin
			pick(3, ad_n);
			pick(3, msg_n);
			pick(block_words + 1, ad_p);
			pick(block_words + 1, msg_p);
			run_op(1'b0, ad_n + 1, msg_n + 1, ad_p, msg_p, -1);
		end
		if (timeouts == 0) begin
			run_op(1'b0, 1, 1, 2, 0, -1);   // empty final words
		end
		if (timeouts == 0) begin
			run_op(1'b1, 2, 2, block_words, 3, -1);
		end
		pick(block_words, pos);
		if (timeouts == 0) begin
			run_op(1'b1, 1, 2, 1, block_words, pos);
		end
		@(posedge clk);

		$display("value errors %0d, wait errors %0d, fail errors %0d, timeouts %0d",
			value_errors, wait_errors, fail_errors, timeouts);
		if (value_errors + wait_errors + fail_errors + timeouts == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/cipher_stub.sv ====
`default_nettype none

module cipher_stub (
	input  logic clk,
	input  logic rst,
	input  aead_ctrl_pkg::state_ctl_t st_ctl,
	input  aead_ctrl_pkg::key_ctl_t key_ctl,
	input  logic [3:0] wait_len,   // 1 to 8 cycles
	output logic [aead_ctrl_pkg::rc_width-1:0] rc
);

	import aead_ctrl_pkg::*;

	localparam logic [rc_width-1:0] rc_busy = 7'h01;

	logic running;
	logic [3:0] cnt;

	// block cipher rounds in progress
	assign running = st_ctl.enc && key_ctl.enc && !st_ctl.se;

	always_ff @(posedge clk) begin
		if (rst || !running) begin
			cnt <= '0;
			rc <= rc_busy;
		end else begin
			cnt <= cnt + 1'b1;
			rc <= (cnt == wait_len - 1'b1) ? rc_final : rc_busy;   // one cycle only
		end
	end

endmodule

`default_nettype wire

// ==== hw/aead_ctrl.sv ====
`default_nettype none

module aead_ctrl #(
	parameter int block_words = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic [aead_ctrl_pkg::data_width-1:0] pdi_data,
	input  logic pdi_valid,
	input  logic last,
	input  logic [aead_ctrl_pkg::data_width-1:0] pdo,
	input  logic [aead_ctrl_pkg::rc_width-1:0] rc,
	output logic [aead_ctrl_pkg::data_width-1:0] pdi,
	output logic pdi_ready,
	output logic pdo_valid,
	output aead_ctrl_pkg::state_ctl_t st_ctl,
	output aead_ctrl_pkg::key_ctl_t key_ctl,
	output logic erst,
	output logic sl,
	output logic [3:0] decrypt,
	output logic correct_cnt,
	output logic fail,
	output logic [aead_ctrl_pkg::dom_width-1:0] dom_old,
	output logic [aead_ctrl_pkg::dom_width-1:0] dom_new
);

	import aead_ctrl_pkg::*;

	cmd_kind_e cmd_kind;
	pdi_sel_e pdi_sel;
	logic cmd_accept;
	logic is_dec;
	logic [len_width-1:0] ad_len;
	logic [len_width-1:0] msg_len;
	logic word_taken;
	logic final_word;
	logic msg_phase;
	logic dom_clear;
	logic verify_en;
	logic verify_last;

	cmd_decoder u_decoder (
		.clk        (clk),
		.rst        (rst),
		.cmd_accept (cmd_accept),
		.pdi_valid  (pdi_valid),
		.pdi_data   (pdi_data),
		.cmd_kind   (cmd_kind),
		.is_dec     (is_dec),
		.ad_len     (ad_len),
		.msg_len    (msg_len)
	);

	block_formatter u_formatter (
		.clk        (clk),
		.rst        (rst),
		.pdi_valid  (pdi_valid),
		.last       (last),
		.final_word (final_word),
		.msg_phase  (msg_phase),
		.dom_clear  (dom_clear),
		.pdi_sel    (pdi_sel),
		.pdi_data   (pdi_data),
		.ad_len     (ad_len),
		.msg_len    (msg_len),
		.pdi        (pdi),
		.word_taken (word_taken),
		.dom_new    (dom_new),
		.dom_old    (dom_old)
	);

	tag_checker u_checker (
		.clk         (clk),
		.rst         (rst),
		.verify_en   (verify_en),
		.verify_last (verify_last),
		.pdo         (pdo),
		.fail        (fail)
	);

	aead_sequencer #(
		.block_words (block_words)
	) u_seq (
		.clk         (clk),
		.rst         (rst),
		.pdi_valid   (pdi_valid),
		.word_taken  (word_taken),
		.is_dec      (is_dec),
		.cmd_kind    (cmd_kind),
		.rc          (rc),
		.cmd_accept  (cmd_accept),
		.dom_clear   (dom_clear),
		.final_word  (final_word),
		.msg_phase   (msg_phase),
		.verify_en   (verify_en),
		.verify_last (verify_last),
		.pdi_sel     (pdi_sel),
		.pdi_ready   (pdi_ready),
		.pdo_valid   (pdo_valid),
		.st_ctl      (st_ctl),
		.key_ctl     (key_ctl),
		.erst        (erst),
		.sl          (sl),
		.correct_cnt (correct_cnt),
		.decrypt     (decrypt)
	);

endmodule

`default_nettype wire

// ==== hw/aead_sequencer.sv ====
`default_nettype none

module aead_sequencer #(
	parameter int block_words = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic pdi_valid,
	input  logic word_taken,
	input  logic is_dec,
	input  aead_ctrl_pkg::cmd_kind_e cmd_kind,
	input  logic [aead_ctrl_pkg::rc_width-1:0] rc,
	output logic cmd_accept,
	output logic dom_clear,
	output logic final_word,
	output logic msg_phase,
	output logic verify_en,
	output logic verify_last,
	output aead_ctrl_pkg::pdi_sel_e pdi_sel,
	output logic pdi_ready,
	output logic pdo_valid,
	output aead_ctrl_pkg::state_ctl_t st_ctl,
	output aead_ctrl_pkg::key_ctl_t key_ctl,
	output logic erst,
	output logic sl,
	output logic correct_cnt,
	output logic [3:0] decrypt
);

	import aead_ctrl_pkg::*;

	localparam int idx_width = (block_words > 1) ? $clog2(block_words) : 1;

	typedef enum logic [3:0] {
		ph_idle,
		ph_key,
		ph_nonce,
		ph_nonce_wait,
		ph_lmask,
		ph_ad,
		ph_ad_wait,
		ph_msg,
		ph_msg_wait,
		ph_tag_out,
		ph_tag_verify
	} phase_e;

	phase_e phase, phase_nxt;
	logic [idx_width-1:0] idx, idx_nxt;
	logic last_idx;
	logic cipher_done;
	logic ready_lvl;   // pdi_ready outside block formatting

	assign last_idx = (idx == idx_width'(block_words - 1));
	assign cipher_done = (rc == rc_final);
	assign pdi_ready = ready_lvl | word_taken;

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= ph_idle;
			idx <= '0;
		end else begin
			phase <= phase_nxt;
			idx <= idx_nxt;
		end
	end

	always_comb begin
		phase_nxt = phase;
		idx_nxt = '0;
		cmd_accept = 1'b0;
		dom_clear = 1'b0;
		final_word = 1'b0;
		msg_phase = 1'b0;
		verify_en = 1'b0;
		verify_last = 1'b0;
		pdi_sel = sel_pass;
		ready_lvl = 1'b0;
		pdo_valid = 1'b0;
		st_ctl = '0;
		key_ctl = '0;
		erst = 1'b0;
		sl = 1'b0;
		correct_cnt = 1'b1;
		decrypt = '0;

		// word phases step through the block
		if (phase inside {ph_key, ph_nonce, ph_lmask, ph_ad, ph_msg,
				ph_tag_out, ph_tag_verify}) begin
			idx_nxt = last_idx ? '0 : idx + 1'b1;
		end

		case (phase)
			ph_idle: begin
				cmd_accept = 1'b1;
				dom_clear = 1'b1;
				ready_lvl = 1'b1;
				st_ctl.rst = 1'b1;
				st_ctl.enc = 1'b1;
				st_ctl.se = 1'b1;
				case (cmd_kind)
					cmd_load_key: phase_nxt = ph_key;
					cmd_encrypt, cmd_decrypt: phase_nxt = ph_nonce;
					default: phase_nxt = ph_idle;
				endcase
			end
			ph_key: begin
				key_ctl.rst = 1'b1;
				key_ctl.enc = 1'b1;
				key_ctl.se = 1'b1;
				if (last_idx) phase_nxt = ph_idle;
			end
			ph_nonce: begin
				ready_lvl = 1'b1;   // nonce word assumed present
				st_ctl.enc = 1'b1;
				st_ctl.se = 1'b1;
				erst = 1'b1;
				if (last_idx) phase_nxt = ph_nonce_wait;
			end
			ph_nonce_wait: begin
				correct_cnt = 1'b0;
				st_ctl.enc = 1'b1;
				key_ctl.enc = 1'b1;
				if (cipher_done) begin
					ready_lvl = 1'b1;
					phase_nxt = ph_lmask;
				end
			end
			ph_lmask: begin
				pdi_sel = sel_zero;
				sl = 1'b1;
				st_ctl.enc = 1'b1;
				st_ctl.se = 1'b1;
				key_ctl.rst = 1'b1;
				key_ctl.enc = 1'b1;
				key_ctl.se = 1'b1;
				if (last_idx) begin
					st_ctl.rst = 1'b1;
					phase_nxt = ph_ad;
				end
			end
			ph_ad, ph_msg: begin
				msg_phase = (phase == ph_msg);
				pdi_sel = sel_block;
				st_ctl.enc = 1'b1;
				st_ctl.se = 1'b1;
				if (phase == ph_msg) begin
					pdo_valid = pdi_valid;
					decrypt = is_dec ? 4'hf : 4'h0;
				end
				if (last_idx) begin
					final_word = 1'b1;   // domain set here
					key_ctl.enc = 1'b1;
					key_ctl.se = 1'b1;
					erst = 1'b1;
					phase_nxt = (phase == ph_msg) ? ph_msg_wait : ph_ad_wait;
				end
			end
			ph_ad_wait: begin
				correct_cnt = 1'b0;
				st_ctl.enc = 1'b1;
				key_ctl.enc = 1'b1;
				if (cipher_done) begin
					if (pdi_valid) begin
						phase_nxt = ph_ad;
					end else begin
						ready_lvl = 1'b1;
						phase_nxt = ph_msg;
					end
				end
			end
			ph_msg_wait: begin
				msg_phase = 1'b1;
				correct_cnt = 1'b0;
				st_ctl.enc = 1'b1;
				key_ctl.enc = 1'b1;
				if (cipher_done) begin
					if (pdi_valid) begin
						phase_nxt = ph_msg;
					end else if (is_dec) begin
						phase_nxt = ph_tag_verify;
					end else begin
						phase_nxt = ph_tag_out;
					end
				end
			end
			ph_tag_out: begin
				pdi_sel = sel_zero;
				pdo_valid = 1'b1;
				st_ctl.enc = 1'b1;
				st_ctl.se = 1'b1;
				if (last_idx) phase_nxt = ph_idle;
			end
			ph_tag_verify: begin
				verify_en = 1'b1;
				if (last_idx) begin
					verify_last = 1'b1;   // fail valid with pdo_valid
					pdo_valid = 1'b1;
					phase_nxt = ph_idle;
				end
			end
			default: phase_nxt = ph_idle;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/tag_checker.sv ====
`default_nettype none

module tag_checker (
	input  logic clk,
	input  logic rst,
	input  logic verify_en,
	input  logic verify_last,
	input  logic [aead_ctrl_pkg::data_width-1:0] pdo,
	output logic fail
);

	logic mismatch;   // any earlier tag word nonzero
	logic word_bad;

	assign word_bad = (pdo != '0);

	// last word counts as well as the ones before it
	assign fail = verify_last && (mismatch || word_bad);

	always_ff @(posedge clk) begin
		if (rst) begin
			mismatch <= 1'b0;
		end else if (verify_last) begin
			mismatch <= 1'b0;   // ready for next operation
		end else if (verify_en && word_bad) begin
			mismatch <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/block_formatter.sv ====
`default_nettype none

module block_formatter (
	input  logic clk,
	input  logic rst,
	input  logic pdi_valid,
	input  logic last,
	input  logic final_word,
	input  logic msg_phase,
	input  logic dom_clear,
	input  aead_ctrl_pkg::pdi_sel_e pdi_sel,
	input  logic [aead_ctrl_pkg::data_width-1:0] pdi_data,
	input  logic [aead_ctrl_pkg::len_width-1:0] ad_len,
	input  logic [aead_ctrl_pkg::len_width-1:0] msg_len,
	output logic [aead_ctrl_pkg::data_width-1:0] pdi,
	output logic word_taken,
	output logic [aead_ctrl_pkg::dom_width-1:0] dom_new,
	output logic [aead_ctrl_pkg::dom_width-1:0] dom_old
);

	import aead_ctrl_pkg::*;

	logic [len_width-1:0] len;
	logic [dom_width-1:0] dom_normal;
	logic [dom_width-1:0] dom_final;
	logic [dom_width-1:0] dom_padded;

	assign len = msg_phase ? msg_len : ad_len;
	assign dom_normal = msg_phase ? dom_msg_normal : dom_ad_normal;
	assign dom_final = msg_phase ? dom_msg_final : dom_ad_final;
	assign dom_padded = msg_phase ? dom_msg_padded : dom_ad_padded;

	always_comb begin
		pdi = pdi_data;
		word_taken = 1'b0;
		dom_new = dom_clear ? '0 : dom_old;
		case (pdi_sel)
			sel_zero: pdi = '0;
			sel_block: begin
				word_taken = pdi_valid;
				if (!final_word) begin
					pdi = pdi_valid ? pdi_data : '0;   // missing word is padding
				end else if (pdi_valid && last) begin
					if (len == '0) begin
						dom_new = dom_final;
					end else begin
						dom_new = dom_padded;
						pdi = {pdi_data[data_width-1:len_width], len};
					end
				end else if (pdi_valid) begin
					dom_new = dom_normal;
				end else begin
					dom_new = dom_padded;
					pdi = data_width'(len);
				end
			end
			default: pdi = pdi_data;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dom_old <= '0;
		end else begin
			dom_old <= dom_new;
		end
	end

endmodule

`default_nettype wire

// ==== hw/cmd_decoder.sv ====
`default_nettype none

module cmd_decoder (
	input  logic clk,
	input  logic rst,
	input  logic cmd_accept,
	input  logic pdi_valid,
	input  logic [aead_ctrl_pkg::data_width-1:0] pdi_data,
	output aead_ctrl_pkg::cmd_kind_e cmd_kind,
	output logic is_dec,
	output logic [aead_ctrl_pkg::len_width-1:0] ad_len,
	output logic [aead_ctrl_pkg::len_width-1:0] msg_len
);

	import aead_ctrl_pkg::*;

	logic [op_width-1:0] opcode;
	logic is_cipher_op;

	assign opcode = pdi_data[data_width-1 -: op_width];

	always_comb begin
		cmd_kind = cmd_none;
		if (pdi_valid) begin
			case (opcode)
				op_ldkey: cmd_kind = cmd_load_key;
				op_enc:   cmd_kind = cmd_encrypt;
				op_dec:   cmd_kind = cmd_decrypt;
				default:  cmd_kind = cmd_none;   // other opcodes ignored
			endcase
		end
	end

	assign is_cipher_op = (cmd_kind == cmd_encrypt) || (cmd_kind == cmd_decrypt);

	// mode and lengths stay fixed for the whole operation
	always_ff @(posedge clk) begin
		if (rst) begin
			is_dec <= 1'b0;
			ad_len <= '0;
			msg_len <= '0;
		end else if (cmd_accept && is_cipher_op) begin
			is_dec <= (cmd_kind == cmd_decrypt);
			msg_len <= pdi_data[len_width-1:0];
			ad_len <= pdi_data[2*len_width-1:len_width];
		end
	end

endmodule

`default_nettype wire

// ==== hw/aead_ctrl_pkg.sv ====
`default_nettype none

package aead_ctrl_pkg;

	localparam int data_width = 32;
	localparam int len_width = 4;   // padding length field
	localparam int dom_width = 8;
	localparam int rc_width = 7;
	localparam int op_width = 4;    // opcode sits in the top nibble

	// instruction opcodes
	localparam logic [op_width-1:0] op_ldkey = 4'd4;
	localparam logic [op_width-1:0] op_enc = 4'd2;
	localparam logic [op_width-1:0] op_dec = 4'd3;

	// round constant of the last SKINNY round
	localparam logic [rc_width-1:0] rc_final = 7'b0110110;

	// domain separation bytes
	localparam logic [dom_width-1:0] dom_ad_normal = 8'd4;
	localparam logic [dom_width-1:0] dom_ad_final = 8'd12;
	localparam logic [dom_width-1:0] dom_ad_padded = 8'd13;
	localparam logic [dom_width-1:0] dom_msg_normal = 8'd2;
	localparam logic [dom_width-1:0] dom_msg_final = 8'd10;
	localparam logic [dom_width-1:0] dom_msg_padded = 8'd11;

	typedef enum logic [1:0] {
		cmd_none,
		cmd_load_key,
		cmd_encrypt,
		cmd_decrypt
	} cmd_kind_e;

	// strobes of the tweakey/state register
	typedef struct packed {
		logic rst;
		logic enc;
		logic se;
	} state_ctl_t;

	typedef struct packed {
		logic rst;
		logic enc;
		logic se;
	} key_ctl_t;

	typedef enum logic [1:0] {
		sel_pass,   // input word as is
		sel_zero,
		sel_block   // padding rule applies
	} pdi_sel_e;

endpackage

`default_nettype wire
